/* aib_link_top.f */
aib_sb_pkg.sv
aib_cfg_pkg.sv
aib_sb_shift.sv
aib_cal_model.sv
aib_link_fsm.sv
aib_csr.sv
aib_channel.sv
aib_link_top.sv
tb_aib_link.sv

/* run.sh */
#!/usr/bin/env bash
# Build the link testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_aib_link -f aib_link_top.f -o tb_aib_link

# a failing run still prints its output, the grep decides the status
out=$(./obj_dir/tb_aib_link) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

/* tb_aib_link.sv */
`timescale 1ns/1ns

module tb_aib_link;
    import aib_sb_pkg::*;
    import aib_cfg_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int FRAME_W         = SB_FLAG_W + USER_W_DEF;
    localparam int SB_HOP_MIN      = FRAME_W + 1;  // one frame plus the load cycle
    localparam int CAL_MAX         = 20;
    localparam int BOUND_MAX       = 4 * FRAME_W + 2 * CAL_MAX + 100;
    localparam int WATCHDOG_CYCLES = 14 * BOUND_MAX + 1500;  // all polls plus APB traffic
    localparam bit MS              = 1'b0;
    localparam bit SL              = 1'b1;

    logic     osc_clk;
    logic     rst_n;
    apb_req_t apb_ms_req;
    apb_rsp_t apb_ms_rsp;
    apb_req_t apb_sl_req;
    apb_rsp_t apb_sl_rsp;
    logic     ms_tx_transfer_en;
    logic     ms_rx_transfer_en;
    logic     sl_tx_transfer_en;
    logic     sl_rx_transfer_en;
    logic [3:0] enables;

    int cycles = 0;
    int poll_bound;   // sideband and link-up wait limit
    int dcc_len;
    int dll_len;

    assign enables = {ms_tx_transfer_en, ms_rx_transfer_en, sl_tx_transfer_en, sl_rx_transfer_en};

    aib_link_top dut (
        .osc_clk(osc_clk), .rst_n(rst_n),
        .apb_ms_req(apb_ms_req), .apb_ms_rsp(apb_ms_rsp),
        .apb_sl_req(apb_sl_req), .apb_sl_rsp(apb_sl_rsp),
        .ms_tx_transfer_en(ms_tx_transfer_en), .ms_rx_transfer_en(ms_rx_transfer_en),
        .sl_tx_transfer_en(sl_tx_transfer_en), .sl_rx_transfer_en(sl_rx_transfer_en)
    );

    initial begin
        osc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) osc_clk = ~osc_clk;
    end

    always @(posedge osc_clk) cycles <= cycles + 1;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the test sequence finished");
    end

    // ========================================================================
    // reporting and expected values
    // ========================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s actual 0x%08h expected 0x%08h", name, act, exp));
        end
    endtask

    // enables are only up in LS_LINK_UP
    function automatic logic [31:0] ref_status(input link_state_t st);
        logic en;
        en = (st == LS_LINK_UP);
        return {26'b0, en, en, 1'b0, st};
    endfunction

    function automatic string side_name(input bit side);
        return side ? "sl" : "ms";
    endfunction

    // ========================================================================
    // APB access on the falling edge
    // ========================================================================

    task automatic drive_req(input bit side, input apb_req_t req);
        if (side) apb_sl_req = req;
        else      apb_ms_req = req;
    endtask

    task automatic apb_transfer(input bit side, input bit write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        apb_req_t req;
        apb_rsp_t rsp;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(negedge osc_clk);
        drive_req(side, req);                // setup phase
        @(negedge osc_clk);
        req.penable = 1'b1;
        drive_req(side, req);
        #2;                                  // middle of the access cycle
        rsp   = side ? apb_sl_rsp : apb_ms_rsp;
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        check_val({side_name(side), " pready"}, 32'(rsp.pready), 32'h1);
        @(negedge osc_clk);
        drive_req(side, '0);
    endtask

    task automatic apb_write(input bit side, input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(side, 1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic apb_read(input bit side, input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(side, 1'b0, addr, 32'h0, data, err);
    endtask

    task automatic write_check(input bit side, input logic [7:0] addr, input logic [31:0] data,
                               input logic exp_err);
        logic err;
        apb_write(side, addr, data, err);
        check_val($sformatf("%s pslverr wr 0x%02h", side_name(side), addr), 32'(err),
                  32'(exp_err));
    endtask

    task automatic read_check(input bit side, input logic [7:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] data;
        logic        err;
        apb_read(side, addr, data, err);
        check_val({side_name(side), " pslverr rd"}, 32'(err), 32'h0);
        check_val({side_name(side), " ", name}, data, exp);
    endtask

    task automatic poll_reg(input bit side, input logic [7:0] addr, input logic [31:0] exp,
                            input string name);
        logic [31:0] data;
        logic        err;
        int          start;
        start = cycles;
        apb_read(side, addr, data, err);
        while (data !== exp) begin
            if (cycles - start > poll_bound) begin
                abort_run($sformatf("%s %s did not reach 0x%08h within %0d cycles",
                                    side_name(side), name, exp, poll_bound));
            end else begin
                apb_read(side, addr, data, err);
            end
        end
    endtask

    task automatic set_cal(input int dcc, input int dll);
        dcc_len    = dcc;
        dll_len    = dll;
        poll_bound = 4 * FRAME_W + dcc_len + dll_len + 100;
        write_check(MS, REG_CAL, {16'b0, 8'(dll), 8'(dcc)}, 1'b0);
        write_check(SL, REG_CAL, {16'b0, 8'(dll), 8'(dcc)}, 1'b0);
    endtask

    // random user bits both ways across the sideband
    task automatic user_exchange();
        logic [31:0] ms_bits;
        logic [31:0] sl_bits;
        ms_bits = 32'(user_bits_t'($urandom));
        sl_bits = 32'(user_bits_t'($urandom));
        write_check(MS, REG_USER_TX, ms_bits, 1'b0);
        poll_reg(SL, REG_USER_RX, ms_bits, "USER_RX");
        write_check(SL, REG_USER_TX, sl_bits, 1'b0);
        poll_reg(MS, REG_USER_RX, sl_bits, "USER_RX");
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        int t0;
        apb_ms_req = '0;
        apb_sl_req = '0;
        rst_n      = 1'b0;
        void'($urandom(39));
        dcc_len    = 4;
        dll_len    = 4;
        poll_bound = 4 * FRAME_W + dcc_len + dll_len + 100;
        repeat (3) @(posedge osc_clk);
        @(negedge osc_clk);
        rst_n = 1'b1;

        // reset values
        @(negedge osc_clk);
        check_val("transfer enables", 32'(enables), 32'h0);
        read_check(MS, REG_STATUS, ref_status(LS_WAIT_CFG), "STATUS");
        read_check(SL, REG_STATUS, ref_status(LS_WAIT_CFG), "STATUS");
        read_check(MS, REG_CAL, 32'h0000_0404, "CAL");
        read_check(SL, REG_CAL, 32'h0000_0404, "CAL");
        read_check(MS, REG_USER_RX, 32'h0, "USER_RX");
        read_check(SL, REG_USER_RX, 32'h0, "USER_RX");

        // register round trip and error responses
        write_check(MS, REG_CTRL, 32'h1, 1'b0);
        read_check(MS, REG_CTRL, 32'h1, "CTRL");
        write_check(MS, REG_CTRL, 32'h0, 1'b0);
        read_check(MS, REG_CTRL, 32'h0, "CTRL");
        write_check(MS, REG_CAL, 32'h0000_0B07, 1'b0);
        read_check(MS, REG_CAL, 32'h0000_0B07, "CAL");
        write_check(MS, REG_USER_TX, 32'h0000_A5C3, 1'b0);
        read_check(MS, REG_USER_TX, 32'h0000_A5C3, "USER_TX");
        write_check(MS, REG_USER_RX, 32'hFFFF_FFFF, 1'b1);
        write_check(MS, REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        write_check(MS, 8'h14, 32'h1, 1'b1);
        write_check(SL, 8'h40, 32'h1, 1'b1);
        read_check(MS, REG_CTRL, 32'h0, "CTRL");
        read_check(MS, REG_CAL, 32'h0000_0B07, "CAL");
        read_check(MS, REG_USER_TX, 32'h0000_A5C3, "USER_TX");
        read_check(MS, REG_USER_RX, 32'h0, "USER_RX");
        read_check(MS, REG_STATUS, ref_status(LS_WAIT_CFG), "STATUS");
        read_check(SL, REG_CTRL, 32'h0, "CTRL");

        user_exchange();                      // link still down

        // master alone must stall in LS_OSC_XFER
        set_cal(2 + int'($urandom % 19), 2 + int'($urandom % 19));
        write_check(MS, REG_CTRL, 32'h1, 1'b0);
        repeat (poll_bound) begin
            @(negedge osc_clk);
            check_val("transfer enables", 32'(enables), 32'h0);
        end
        read_check(MS, REG_STATUS, ref_status(LS_OSC_XFER), "STATUS");
        read_check(SL, REG_STATUS, ref_status(LS_WAIT_CFG), "STATUS");

        write_check(SL, REG_CTRL, 32'h1, 1'b0);
        t0 = cycles;
        poll_reg(MS, REG_STATUS, ref_status(LS_LINK_UP), "STATUS");
        poll_reg(SL, REG_STATUS, ref_status(LS_LINK_UP), "STATUS");
        // three sideband hops in series with both calibrations
        if (cycles - t0 < 3 * SB_HOP_MIN + dcc_len + dll_len) begin
            abort_run($sformatf("link came up after %0d cycles, bring-up needs at least %0d",
                                cycles - t0, 3 * SB_HOP_MIN + dcc_len + dll_len));
        end
        check_val("transfer enables", 32'(enables), 32'hF);

        user_exchange();
        read_check(MS, REG_STATUS, ref_status(LS_LINK_UP), "STATUS");
        read_check(SL, REG_STATUS, ref_status(LS_LINK_UP), "STATUS");

        // teardown from the slave while the master restarts into LS_OSC_XFER
        write_check(SL, REG_CTRL, 32'h0, 1'b0);
        poll_reg(SL, REG_STATUS, ref_status(LS_WAIT_CFG), "STATUS");
        poll_reg(MS, REG_STATUS, ref_status(LS_OSC_XFER), "STATUS");
        check_val("transfer enables", 32'(enables), 32'h0);
        write_check(SL, REG_CTRL, 32'h1, 1'b0);
        poll_reg(MS, REG_STATUS, ref_status(LS_LINK_UP), "STATUS");
        poll_reg(SL, REG_STATUS, ref_status(LS_LINK_UP), "STATUS");
        check_val("transfer enables", 32'(enables), 32'hF);

        $display("Test passed");
        $finish;
    end

endmodule

/* aib_link_top.sv */
`timescale 1ns/1ns

module aib_link_top #(
    parameter int USER_W = aib_sb_pkg::USER_W_DEF
) (
    input  logic                  osc_clk,
    input  logic                  rst_n,
    input  aib_cfg_pkg::apb_req_t apb_ms_req,
    output aib_cfg_pkg::apb_rsp_t apb_ms_rsp,
    input  aib_cfg_pkg::apb_req_t apb_sl_req,
    output aib_cfg_pkg::apb_rsp_t apb_sl_rsp,
    output logic                  ms_tx_transfer_en,
    output logic                  ms_rx_transfer_en,
    output logic                  sl_tx_transfer_en,
    output logic                  sl_rx_transfer_en
);

    logic ms_sb_data;   // master to slave
    logic ms_sb_load;
    logic sl_sb_data;   // slave to master
    logic sl_sb_load;

    aib_channel #(.USER_W(USER_W)) u_ms (
        .osc_clk(osc_clk), .rst_n(rst_n),
        .apb_req(apb_ms_req), .apb_rsp(apb_ms_rsp),
        .sb_data(ms_sb_data), .sb_load(ms_sb_load),
        .sb_data_in(sl_sb_data), .sb_load_in(sl_sb_load),
        .tx_transfer_en(ms_tx_transfer_en), .rx_transfer_en(ms_rx_transfer_en)
    );

    aib_channel #(.USER_W(USER_W)) u_sl (
        .osc_clk(osc_clk), .rst_n(rst_n),
        .apb_req(apb_sl_req), .apb_rsp(apb_sl_rsp),
        .sb_data(sl_sb_data), .sb_load(sl_sb_load),
        .sb_data_in(ms_sb_data), .sb_load_in(ms_sb_load),
        .tx_transfer_en(sl_tx_transfer_en), .rx_transfer_en(sl_rx_transfer_en)
    );

endmodule

/* aib_channel.sv */
`timescale 1ns/1ns

module aib_channel #(
    parameter int USER_W = aib_sb_pkg::USER_W_DEF
) (
    input  logic                  osc_clk,
    input  logic                  rst_n,
    input  aib_cfg_pkg::apb_req_t apb_req,
    output aib_cfg_pkg::apb_rsp_t apb_rsp,
    output logic                  sb_data,
    output logic                  sb_load,
    input  logic                  sb_data_in,
    input  logic                  sb_load_in,
    output logic                  tx_transfer_en,
    output logic                  rx_transfer_en
);
    import aib_sb_pkg::*;
    import aib_cfg_pkg::*;

    logic                        config_done;
    cal_len_t                    dcc_len;
    cal_len_t                    dll_len;
    logic [USER_W-1:0]           user_tx;
    logic [USER_W-1:0]           user_rx;
    sb_flags_t                   local_flags;
    sb_flags_t                   remote_flags;
    link_state_t                 state;
    logic                        dcc_req;
    logic                        dll_req;
    logic                        dcc_done;
    logic                        dll_lock;
    logic [SB_FLAG_W+USER_W-1:0] tx_word;

    assign tx_word        = {local_flags, user_tx};   // flags lead the frame
    assign tx_transfer_en = local_flags.tx_transfer_en;
    assign rx_transfer_en = local_flags.rx_transfer_en;

    aib_csr #(.USER_W(USER_W)) u_csr (
        .osc_clk(osc_clk), .rst_n(rst_n),
        .apb_req(apb_req), .apb_rsp(apb_rsp),
        .state(state), .local_flags(local_flags), .user_rx(user_rx),
        .config_done(config_done), .dcc_len(dcc_len), .dll_len(dll_len),
        .user_tx(user_tx)
    );

    aib_link_fsm u_fsm (
        .osc_clk(osc_clk), .rst_n(rst_n),
        .config_done(config_done), .remote_flags(remote_flags),
        .dcc_done(dcc_done), .dll_lock(dll_lock),
        .dcc_req(dcc_req), .dll_req(dll_req),
        .local_flags(local_flags), .state(state)
    );

    aib_cal_model u_cal (
        .osc_clk(osc_clk), .rst_n(rst_n),
        .dcc_len(dcc_len), .dll_len(dll_len),
        .dcc_req(dcc_req), .dll_req(dll_req),
        .dcc_done(dcc_done), .dll_lock(dll_lock)
    );

    aib_sb_shift #(.USER_W(USER_W)) u_sb (
        .osc_clk(osc_clk), .rst_n(rst_n), .tx_word(tx_word),
        .sb_data(sb_data), .sb_load(sb_load),
        .sb_data_in(sb_data_in), .sb_load_in(sb_load_in),
        .remote_flags(remote_flags), .user_rx(user_rx)
    );

endmodule

/* aib_csr.sv */
`timescale 1ns/1ns

module aib_csr #(
    parameter int USER_W = aib_sb_pkg::USER_W_DEF
) (
    input  logic                    osc_clk,
    input  logic                    rst_n,
    input  aib_cfg_pkg::apb_req_t   apb_req,
    output aib_cfg_pkg::apb_rsp_t   apb_rsp,
    input  aib_sb_pkg::link_state_t state,
    input  aib_sb_pkg::sb_flags_t   local_flags,
    input  logic [USER_W-1:0]       user_rx,
    output logic                    config_done,
    output aib_cfg_pkg::cal_len_t   dcc_len,
    output aib_cfg_pkg::cal_len_t   dll_len,
    output logic [USER_W-1:0]       user_tx
);
    import aib_cfg_pkg::*;

    logic      access;     // APB access phase
    logic      mapped;
    logic      read_only;
    logic      wr_en;
    apb_data_t rdata;

    assign access = apb_req.psel && apb_req.penable;

    // ========================================================================
    // address decode and read mux
    // ========================================================================

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        rdata     = '0;
        case (apb_req.paddr)
            REG_CTRL:    rdata = {31'b0, config_done};
            REG_CAL:     rdata = {16'b0, dll_len, dcc_len};
            REG_USER_TX: rdata = apb_data_t'(user_tx);
            REG_USER_RX: begin
                rdata     = apb_data_t'(user_rx);
                read_only = 1'b1;
            end
            REG_STATUS: begin
                rdata     = {26'b0, local_flags.rx_transfer_en,
                             local_flags.tx_transfer_en, 1'b0, state};
                read_only = 1'b1;
            end
            default: mapped = 1'b0;
        endcase
    end

    assign wr_en = access && apb_req.pwrite && mapped && !read_only;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;   // zero wait states
    assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            config_done <= 1'b0;
            dcc_len     <= CAL_LEN_RST;
            dll_len     <= CAL_LEN_RST;
            user_tx     <= '0;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_CTRL: config_done <= apb_req.pwdata[0];
                REG_CAL: begin
                    dcc_len <= apb_req.pwdata[7:0];
                    dll_len <= apb_req.pwdata[15:8];
                end
                REG_USER_TX: user_tx <= apb_req.pwdata[USER_W-1:0];
                default: config_done <= config_done;
            endcase
        end
    end

endmodule

/* aib_link_fsm.sv */
`timescale 1ns/1ns

module aib_link_fsm (
    input  logic                    osc_clk,
    input  logic                    rst_n,
    input  logic                    config_done,
    input  aib_sb_pkg::sb_flags_t   remote_flags,
    input  logic                    dcc_done,
    input  logic                    dll_lock,
    output logic                    dcc_req,
    output logic                    dll_req,
    output aib_sb_pkg::sb_flags_t   local_flags,
    output aib_sb_pkg::link_state_t state
);
    import aib_sb_pkg::*;

    logic past_osc;   // remote oscillator must stay alive from here on
    logic drop_link;

    assign past_osc  = (state != LS_WAIT_CFG) && (state != LS_OSC_XFER);
    assign drop_link = !config_done || (past_osc && !remote_flags.osc_transfer_en);

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= LS_WAIT_CFG;
            local_flags <= '0;
            dcc_req     <= 1'b0;
            dll_req     <= 1'b0;
        end else if (drop_link) begin
            state       <= LS_WAIT_CFG;          // full restart
            local_flags <= '0;
            dcc_req     <= 1'b0;
            dll_req     <= 1'b0;
        end else begin
            case (state)
                LS_WAIT_CFG: begin
                    local_flags.osc_transfer_en <= 1'b1;
                    state                       <= LS_OSC_XFER;
                end
                LS_OSC_XFER: begin
                    if (remote_flags.osc_transfer_en) begin
                        dcc_req <= 1'b1;
                        state   <= LS_DCC_CAL;
                    end
                end
                LS_DCC_CAL: begin
                    if (dcc_done) begin
                        dcc_req                     <= 1'b0;
                        local_flags.tx_dcc_cal_done <= 1'b1;
                        state                       <= LS_DLL_LOCK;
                    end
                end
                LS_DLL_LOCK: begin
                    if (dll_req && dll_lock) begin
                        dll_req                 <= 1'b0;
                        local_flags.rx_dll_lock <= 1'b1;
                        state                   <= LS_XFER_EN;
                    end else if (remote_flags.tx_dcc_cal_done) begin
                        dll_req <= 1'b1;                  // far side clock is clean
                    end
                end
                LS_XFER_EN: begin
                    if (remote_flags.rx_dll_lock) begin
                        local_flags.tx_transfer_en <= 1'b1;
                        local_flags.rx_transfer_en <= 1'b1;
                        state                      <= LS_LINK_UP;
                    end
                end
                default: begin
                    state <= LS_LINK_UP;                  // hold until dropped
                end
            endcase
        end
    end

endmodule

/* aib_cal_model.sv */
`timescale 1ns/1ns

module aib_cal_model (
    input  logic                  osc_clk,
    input  logic                  rst_n,
    input  aib_cfg_pkg::cal_len_t dcc_len,
    input  aib_cfg_pkg::cal_len_t dll_len,
    input  logic                  dcc_req,
    input  logic                  dll_req,
    output logic                  dcc_done,
    output logic                  dll_lock
);
    import aib_cfg_pkg::*;

    // index 0 is DCC, index 1 is DLL
    logic [1:0] req;
    logic [1:0] run;      // request seen and counter loaded
    cal_len_t   len [2];
    cal_len_t   cnt [2];

    assign req    = {dll_req, dcc_req};
    assign len[0] = dcc_len;
    assign len[1] = dll_len;

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= '0;
            cnt <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!req[i]) begin
                    run[i] <= 1'b0;                // dropping req clears result
                    cnt[i] <= '0;
                end else if (!run[i]) begin
                    run[i] <= 1'b1;
                    cnt[i] <= (len[i] == '0) ? '0 : len[i] - 1'b1;
                end else if (cnt[i] != '0) begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    assign dcc_done = run[0] && (cnt[0] == '0);
    assign dll_lock = run[1] && (cnt[1] == '0);

endmodule

/* aib_sb_shift.sv */
`timescale 1ns/1ns

module aib_sb_shift #(
    parameter int USER_W = aib_sb_pkg::USER_W_DEF
) (
    input  logic                                    osc_clk,
    input  logic                                    rst_n,
    input  logic [aib_sb_pkg::SB_FLAG_W+USER_W-1:0] tx_word,
    output logic                                    sb_data,
    output logic                                    sb_load,
    input  logic                                    sb_data_in,
    input  logic                                    sb_load_in,
    output aib_sb_pkg::sb_flags_t                   remote_flags,
    output logic [USER_W-1:0]                       user_rx
);
    import aib_sb_pkg::*;

    localparam int FRAME_W = SB_FLAG_W + USER_W;
    localparam int CNT_W   = $clog2(FRAME_W);

    logic [CNT_W-1:0]   frame_cnt;
    logic [FRAME_W-1:0] tx_sr;
    logic [FRAME_W-2:0] rx_sr;    // all but the last bit of a frame
    logic [FRAME_W-1:0] rx_word;  // held received frame

    // ========================================================================
    // transmit, MSB first
    // ========================================================================

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            tx_sr     <= '0;
            sb_load   <= 1'b0;
        end else begin
            if (frame_cnt == CNT_W'(FRAME_W - 1)) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (frame_cnt == '0) begin
                tx_sr <= tx_word;                      // capture new frame
            end else begin
                tx_sr <= {tx_sr[FRAME_W-2:0], 1'b0};
            end
            sb_load <= (frame_cnt == CNT_W'(FRAME_W - 1));  // with last bit
        end
    end

    assign sb_data = tx_sr[FRAME_W-1];

    // ========================================================================
    // receive
    // ========================================================================

    always_ff @(posedge osc_clk) begin
        rx_sr <= {rx_sr[FRAME_W-3:0], sb_data_in};
    end

    always_ff @(posedge osc_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_word <= '0;
        end else if (sb_load_in) begin
            rx_word <= {rx_sr, sb_data_in};  // last bit arrives with load
        end
    end

    assign remote_flags = sb_flags_t'(rx_word[FRAME_W-1 -: SB_FLAG_W]);
    assign user_rx      = rx_word[USER_W-1:0];

endmodule

/* aib_cfg_pkg.sv */
package aib_cfg_pkg;

    typedef logic [7:0]  cal_len_t;   // osc_clk cycles
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // ========================================================================
    // register map
    // ========================================================================

    localparam apb_addr_t REG_CTRL    = 8'h00;  // bit 0 config_done
    localparam apb_addr_t REG_CAL     = 8'h04;  // dll_len, dcc_len
    localparam apb_addr_t REG_USER_TX = 8'h08;
    localparam apb_addr_t REG_USER_RX = 8'h0C;  // read only
    localparam apb_addr_t REG_STATUS  = 8'h10;  // read only

    localparam cal_len_t CAL_LEN_RST = 8'h04;

endpackage

/* aib_sb_pkg.sv */
package aib_sb_pkg;

    // ========================================================================
    // sideband frame layout
    // ========================================================================

    localparam int USER_W_DEF = 16;  // user bits per frame
    localparam int SB_FLAG_W  = 5;   // width of sb_flags_t

    // first field goes out first on the serial line
    typedef struct packed {
        logic osc_transfer_en;
        logic tx_dcc_cal_done;
        logic rx_dll_lock;
        logic tx_transfer_en;
        logic rx_transfer_en;
    } sb_flags_t;

    typedef logic [USER_W_DEF-1:0] user_bits_t;

    // ========================================================================
    // link bring-up
    // ========================================================================

    typedef enum logic [2:0] {
        LS_WAIT_CFG = 3'd0,  // idle until software config
        LS_OSC_XFER = 3'd1,
        LS_DCC_CAL  = 3'd2,
        LS_DLL_LOCK = 3'd3,
        LS_XFER_EN  = 3'd4,
        LS_LINK_UP  = 3'd5
    } link_state_t;

endpackage
